//--- list.f
+incdir+include
rtl/ss_pkg.sv
rtl/ss_bridge_port.sv
rtl/save_state_controller.sv
rtl/ss_bus_decoder.sv
rtl/ss_reg_bank.sv
rtl/ss_read_mux.sv
rtl/ss_subsystem_top.sv
verif/ss_tb.sv

//--- Bender.yml
package:
  name: ss_subsystem

export_include_dirs:
  - include

sources:
  - files:
      - rtl/ss_pkg.sv
      - rtl/ss_bridge_port.sv
      - rtl/save_state_controller.sv
      - rtl/ss_bus_decoder.sv
      - rtl/ss_reg_bank.sv
      - rtl/ss_read_mux.sv
      - rtl/ss_subsystem_top.sv
  - target: test
    files:
      - verif/ss_tb.sv

//--- verif/ss_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ss_tb;
  import ss_pkg::*;
  `include "ss_defines.svh"

  localparam int watchdog_ns = `SS_STATE_WORDS * 40 * 6 * 8;
  localparam logic [31:0] window_base = {4'(`SS_BRIDGE_REGION), 28'h0};
  localparam int read_spacing = 12;
  localparam int write_spacing = 6;
  localparam int handshake_limit = 100;

  logic     clk_sys;
  logic     reset;
  logic     bridge_wr;
  logic     bridge_rd;
  logic [31:0] bridge_addr;
  ss_word_t bridge_wr_data;
  ss_word_t bridge_rd_data;
  logic     savestate_start;
  logic     savestate_load;
  logic     savestate_start_ack;
  logic     savestate_start_busy;
  logic     savestate_start_ok;
  logic     savestate_load_ack;
  logic     savestate_load_busy;
  logic     savestate_load_ok;
  logic     ss_ready;
  logic     ss_halt;
  logic     ss_reset;

  logic [31:0] rng_state;
  // Expected bank contents, in bank-then-index order
  ss_word_t exp_state [`SS_STATE_WORDS];
  ss_word_t old_state [`SS_STATE_WORDS];

  ss_subsystem_top DUT (
    .clk_sys(clk_sys), .reset(reset),
    .bridge_wr(bridge_wr), .bridge_rd(bridge_rd), .bridge_addr(bridge_addr),
    .bridge_wr_data(bridge_wr_data), .bridge_rd_data(bridge_rd_data),
    .savestate_start(savestate_start), .savestate_load(savestate_load),
    .savestate_start_ack(savestate_start_ack), .savestate_start_busy(savestate_start_busy),
    .savestate_start_ok(savestate_start_ok), .savestate_load_ack(savestate_load_ack),
    .savestate_load_busy(savestate_load_busy), .savestate_load_ok(savestate_load_ok),
    .ss_ready(ss_ready), .ss_halt(ss_halt), .ss_reset(ss_reset)
  );

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    stop_failed();
  end

  // Host sees the word with its nibble order reversed
  function automatic ss_word_t reverse_nibbles(input ss_word_t w);
    ss_word_t r;
    r = '0;
    for (int i = 0; i < 8; i++) begin
      r = {r[27:0], w[4*i +: 4]};
    end
    return r;
  endfunction

  function automatic ss_word_t default_word(input int addr);
    return {8'(addr / `SS_BANK_WORDS), 8'(addr % `SS_BANK_WORDS), 16'h5a5a};
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic string state_text();
    ctrl_state_t st;
    st = DUT.u_controller.state;
    return st.name();
  endfunction

  function automatic logic probe(input string name);
    case (name)
      "savestate_start_ack":  return savestate_start_ack;
      "savestate_start_busy": return savestate_start_busy;
      "savestate_load_ack":   return savestate_load_ack;
      default:                return 1'bx;
    endcase
  endfunction

  task automatic next_cycle();
    @(negedge clk_sys);
  endtask

  task automatic stop_failed();
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, expected);
      stop_failed();
    end
  endtask

  task automatic wait_level(input string name, input logic level, input int limit,
                            output int cycles);
    cycles = 0;
    while (probe(name) !== level) begin
      if (cycles >= limit) begin
        $display("Timed out waiting for %s to reach %0b, controller in %s",
                 name, level, state_text());
        stop_failed();
      end
      next_cycle();
      cycles++;
    end
  endtask

  task automatic write_word(input int w, input logic [31:0] data);
    bridge_addr    = window_base + 32'(4 * w);
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    next_cycle();
    bridge_wr = 1'b0;
    repeat (write_spacing - 1) next_cycle();
  endtask

  // One read strobe, data is valid one cycle later
  task automatic read_word(input int w, output logic [31:0] data);
    bridge_addr = window_base + 32'(4 * w);
    bridge_rd   = 1'b1;
    next_cycle();
    bridge_rd = 1'b0;
    data      = bridge_rd_data;
  endtask

  task automatic save_and_compare(input int ready_hold, input bit against_old);
    int          cycles;
    logic [31:0] got;
    ss_ready        = (ready_hold == 0);
    savestate_start = 1'b1;
    wait_level("savestate_start_ack", 1'b1, handshake_limit, cycles);
    savestate_start = 1'b0;
    check("savestate_start_ok", savestate_start_ok, 0);
    check("savestate_start_busy", savestate_start_busy, 0);
    check("savestate_load_ok", savestate_load_ok, 0);
    repeat (`SS_APF_DELAY) begin
      check("savestate_start_ack", savestate_start_ack, 1);
      next_cycle();
    end
    check("savestate_start_ack", savestate_start_ack, 0);
    check("savestate_start_busy", savestate_start_busy, 1);
    if (ready_hold > 0) begin
      repeat (ready_hold) begin
        check("savestate_start_busy", savestate_start_busy, 1);
        check("savestate_start_ok", savestate_start_ok, 0);
        next_cycle();
      end
      ss_ready = 1'b1;
    end
    wait_level("savestate_start_busy", 1'b0, handshake_limit, cycles);
    if (ready_hold == 0) begin
      check("savestate_start_busy cycles", cycles, `SS_APF_DELAY);
    end
    check("savestate_start_ok", savestate_start_ok, 1);
    check("ss_halt", ss_halt, 1);

    for (int w = 0; w < `SS_STATE_WORDS; w++) begin
      repeat (read_spacing - 1) next_cycle();
      read_word(w, got);
      check("ss_halt", ss_halt, 1);
      if (against_old && got === reverse_nibbles(old_state[w])) begin
        $display("Word %0d of the save still holds the previous load", w);
        stop_failed();
      end
      check($sformatf("bridge_rd_data[%0d]", w), got, reverse_nibbles(exp_state[w]));
    end
    repeat (2) next_cycle();
    check("ss_halt", ss_halt, 0);
    check("savestate_start_ok", savestate_start_ok, 1);
  endtask

  task automatic load_random_words();
    int          cycles;
    logic [31:0] host_word;
    for (int w = 0; w < `SS_STATE_WORDS; w++) begin
      host_word    = next_random();
      exp_state[w] = reverse_nibbles(host_word);
      write_word(w, host_word);
      if (w == 0) begin
        check("ss_halt", ss_halt, 1);
      end
    end
    repeat (write_spacing) next_cycle();
    // Every load here follows a save, so start ok holds until the ack
    check("savestate_start_ok", savestate_start_ok, 1);
    savestate_load = 1'b1;
    wait_level("savestate_load_ack", 1'b1, handshake_limit, cycles);
    savestate_load = 1'b0;
    check("savestate_start_ok", savestate_start_ok, 0);
    check("savestate_load_ok", savestate_load_ok, 0);
    check("savestate_load_busy", savestate_load_busy, 0);
    // Ack then busy, each held for a fixed phase
    repeat (`SS_APF_DELAY) begin
      check("savestate_load_ack", savestate_load_ack, 1);
      check("ss_reset", ss_reset, 1);
      next_cycle();
    end
    check("savestate_load_ack", savestate_load_ack, 0);
    repeat (`SS_APF_DELAY) begin
      check("savestate_load_busy", savestate_load_busy, 1);
      check("ss_reset", ss_reset, 1);
      next_cycle();
    end
    check("savestate_load_busy", savestate_load_busy, 0);
    check("savestate_load_ok", savestate_load_ok, 1);
    check("ss_reset", ss_reset, 0);
    repeat (2) next_cycle();
    check("ss_halt", ss_halt, 0);
  endtask

  task automatic reset_outputs_low();
    repeat (2) next_cycle();
    check("savestate_start_ack", savestate_start_ack, 0);
    check("savestate_start_busy", savestate_start_busy, 0);
    check("savestate_start_ok", savestate_start_ok, 0);
    check("savestate_load_ack", savestate_load_ack, 0);
    check("savestate_load_busy", savestate_load_busy, 0);
    check("savestate_load_ok", savestate_load_ok, 0);
    check("ss_halt", ss_halt, 0);
    check("ss_reset", ss_reset, 0);
  endtask

  task automatic save_defaults();
    for (int w = 0; w < `SS_STATE_WORDS; w++) begin
      exp_state[w] = default_word(w);
    end
    save_and_compare(0, 1'b0);
  endtask

  task automatic save_with_ready_low();
    save_and_compare(20, 1'b0);
  endtask

  task automatic load_then_save();
    load_random_words();
    save_and_compare(0, 1'b0);
  endtask

  task automatic reload_overwrites();
    for (int w = 0; w < `SS_STATE_WORDS; w++) begin
      old_state[w] = exp_state[w];
    end
    load_random_words();
    save_and_compare(0, 1'b1);
  endtask

  // Start ok survives until the next load is acknowledged
  task automatic load_clears_start_ok();
    check("savestate_start_ok", savestate_start_ok, 1);
    check("savestate_load_ok", savestate_load_ok, 0);
    load_random_words();
    check("savestate_start_ok", savestate_start_ok, 0);
    save_and_compare(0, 1'b0);
  endtask

  initial begin
    reset           = 1'b1;
    bridge_wr       = 1'b0;
    bridge_rd       = 1'b0;
    bridge_addr     = '0;
    bridge_wr_data  = '0;
    savestate_start = 1'b0;
    savestate_load  = 1'b0;
    ss_ready        = 1'b1;
    rng_state       = 32'h2490_3e6a;
    repeat (5) next_cycle();
    reset = 1'b0;

    $display("Test 1: state after reset");
    reset_outputs_low();
    $display("Test 2: save of the default state");
    save_defaults();
    $display("Test 3: save status with ss_ready held low");
    save_with_ready_low();
    $display("Test 4: load of random words and save back");
    load_then_save();
    $display("Test 5: second load overwrites every bank");
    reload_overwrites();
    $display("Test 6: load acknowledge clears start ok");
    load_clears_start_ok();

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/ss_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module ss_subsystem_top (
  input  wire                   clk_sys,
  input  wire                   reset,
  input  wire                   bridge_wr,
  input  wire                   bridge_rd,
  input  wire [31:0]            bridge_addr,
  input  wire ss_pkg::ss_word_t bridge_wr_data,
  output ss_pkg::ss_word_t      bridge_rd_data,
  input  wire                   savestate_start,
  input  wire                   savestate_load,
  output logic                  savestate_start_ack,
  output logic                  savestate_start_busy,
  output logic                  savestate_start_ok,
  output logic                  savestate_load_ack,
  output logic                  savestate_load_busy,
  output logic                  savestate_load_ok,
  input  wire                   ss_ready,
  output logic                  ss_halt,
  output logic                  ss_reset
);
  import ss_pkg::*;
  `include "ss_defines.svh"

  logic                              load_full;
  logic                              load_take;
  logic                              save_full;
  logic                              save_put;
  ss_word_t                          load_word;
  ss_addr_t                          bus_addr;
  ss_word_t                          bus_wdata;
  ss_word_t                          bus_rdata;
  logic                              bus_wren;
  logic                              bus_reset;
  logic [`SS_NUM_BANKS-1:0]          bank_wren;
  logic [$clog2(`SS_BANK_WORDS)-1:0] word_index;
  logic [$clog2(`SS_NUM_BANKS)-1:0]  bank_sel;
  logic                              bank_reset;
  ss_word_t                          bank_rdata [`SS_NUM_BANKS];

  ss_bridge_port u_bridge_port (
    .clk_sys(clk_sys), .reset(reset),
    .bridge_wr(bridge_wr), .bridge_rd(bridge_rd), .bridge_addr(bridge_addr),
    .bridge_wr_data(bridge_wr_data), .bridge_rd_data(bridge_rd_data),
    .load_take(load_take), .load_full(load_full), .load_word(load_word),
    .save_put(save_put), .bus_rdata(bus_rdata), .save_full(save_full)
  );

  save_state_controller u_controller (
    .clk_sys(clk_sys), .reset(reset),
    .savestate_start(savestate_start), .savestate_load(savestate_load),
    .savestate_start_ack(savestate_start_ack), .savestate_start_busy(savestate_start_busy),
    .savestate_start_ok(savestate_start_ok), .savestate_load_ack(savestate_load_ack),
    .savestate_load_busy(savestate_load_busy), .savestate_load_ok(savestate_load_ok),
    .ss_ready(ss_ready), .ss_halt(ss_halt), .ss_reset(ss_reset),
    .load_full(load_full), .load_word(load_word), .load_take(load_take),
    .save_full(save_full), .save_put(save_put),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_wren(bus_wren), .bus_reset(bus_reset)
  );

  ss_bus_decoder u_decoder (
    .clk_sys(clk_sys), .reset(reset),
    .bus_addr(bus_addr), .bus_wren(bus_wren), .bus_reset(bus_reset),
    .bank_wren(bank_wren), .word_index(word_index), .bank_sel(bank_sel),
    .bank_reset(bank_reset)
  );

  // One bank per emulated block: cpu, ppu, apu, video
  for (genvar i = 0; i < `SS_NUM_BANKS; i++) begin : g_bank
    ss_reg_bank #(.BANK_ID(i)) u_bank (
      .clk_sys(clk_sys), .bank_reset(bank_reset), .wren(bank_wren[i]),
      .word_index(word_index), .wdata(bus_wdata), .rdata(bank_rdata[i])
    );
  end

  ss_read_mux u_read_mux (
    .clk_sys(clk_sys), .bank_sel(bank_sel), .bank_rdata(bank_rdata), .bus_rdata(bus_rdata)
  );

endmodule

`default_nettype wire

//--- rtl/ss_read_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "ss_defines.svh"

module ss_read_mux (
  input  wire                              clk_sys,
  input  wire [$clog2(`SS_NUM_BANKS)-1:0]  bank_sel,
  input  wire ss_pkg::ss_word_t            bank_rdata [`SS_NUM_BANKS],
  output ss_pkg::ss_word_t                 bus_rdata
);

  // Select aligned with the bank read register
  logic [$clog2(`SS_NUM_BANKS)-1:0] sel_q;

  always_ff @(posedge clk_sys) begin
    sel_q     <= bank_sel;
    bus_rdata <= bank_rdata[sel_q];
  end

endmodule

`default_nettype wire

//--- rtl/ss_reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "ss_defines.svh"

module ss_reg_bank #(
  parameter int BANK_ID = 0
) (
  input  wire                               clk_sys,
  input  wire                               bank_reset,
  input  wire                               wren,
  input  wire [$clog2(`SS_BANK_WORDS)-1:0]  word_index,
  input  wire ss_pkg::ss_word_t             wdata,
  output ss_pkg::ss_word_t                  rdata
);
  import ss_pkg::*;

  ss_word_t mem [`SS_BANK_WORDS];

  // Default word is bank id, word index, then a fixed pattern
  function automatic ss_word_t default_word(input int index);
    ss_word_t w;
    w = {8'(BANK_ID), 8'(index), 16'h5a5a};
    return w;
  endfunction

  always_ff @(posedge clk_sys) begin
    if (bank_reset) begin
      for (int i = 0; i < `SS_BANK_WORDS; i++) begin
        mem[i] <= default_word(i);
      end
    end else if (wren) begin
      mem[word_index] <= wdata;
    end
  end

  // Registered read, one cycle after the index
  always_ff @(posedge clk_sys) begin
    rdata <= mem[word_index];
  end

endmodule

`default_nettype wire

//--- rtl/ss_bus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "ss_defines.svh"

module ss_bus_decoder (
  input  wire                               clk_sys,
  input  wire                               reset,
  input  wire ss_pkg::ss_addr_t             bus_addr,
  input  wire                               bus_wren,
  input  wire                               bus_reset,
  output logic [`SS_NUM_BANKS-1:0]          bank_wren,
  output logic [$clog2(`SS_BANK_WORDS)-1:0] word_index,
  output logic [$clog2(`SS_NUM_BANKS)-1:0]  bank_sel,
  output logic                              bank_reset
);

  localparam int idx_w = $clog2(`SS_BANK_WORDS);
  localparam int sel_w = $clog2(`SS_NUM_BANKS);

  logic             in_range;
  logic [sel_w-1:0] bank_num;

  // Addresses above the last bank select nothing
  assign in_range = bus_addr[7:idx_w+sel_w] == '0;
  assign bank_num = bus_addr[idx_w +: sel_w];

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      bank_wren  <= '0;
      bank_reset <= 1'b0;
    end else begin
      bank_wren  <= (bus_wren && in_range) ? (`SS_NUM_BANKS)'(1) << bank_num : '0;
      bank_reset <= bus_reset;
    end
  end

  always_ff @(posedge clk_sys) begin
    word_index <= bus_addr[idx_w-1:0];
    bank_sel   <= bank_num;
  end

endmodule

`default_nettype wire

//--- rtl/save_state_controller.sv
`timescale 1ns/10ps
`default_nettype none

module save_state_controller (
  input  wire              clk_sys,
  input  wire              reset,
  input  wire              savestate_start,
  input  wire              savestate_load,
  output logic             savestate_start_ack,
  output logic             savestate_start_busy,
  output logic             savestate_start_ok,
  output logic             savestate_load_ack,
  output logic             savestate_load_busy,
  output logic             savestate_load_ok,
  input  wire              ss_ready,
  output logic             ss_halt,
  output logic             ss_reset,
  input  wire              load_full,
  input  wire ss_pkg::ss_word_t load_word,
  output logic             load_take,
  input  wire              save_full,
  output logic             save_put,
  output ss_pkg::ss_addr_t bus_addr,
  output ss_pkg::ss_word_t bus_wdata,
  output logic             bus_wren,
  output logic             bus_reset
);
  import ss_pkg::*;
  `include "ss_defines.svh"

  localparam int delay_w = $clog2(`SS_APF_DELAY + 1);
  localparam int wait_w = $clog2(`SS_READ_WAIT + 1);
  localparam logic [delay_w-1:0] phase_len = delay_w'(`SS_APF_DELAY - 1);
  localparam ss_addr_t last_addr = ss_addr_t'(`SS_STATE_WORDS - 1);

  ctrl_state_t        state;
  logic [delay_w-1:0] apf_delay;
  // Counts from 1 on the cycle after bus_addr changes
  logic [wait_w-1:0]  wait_cnt;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      state                <= idle;
      apf_delay            <= '0;
      wait_cnt             <= '0;
      savestate_start_ack  <= 1'b0;
      savestate_start_busy <= 1'b0;
      savestate_start_ok   <= 1'b0;
      savestate_load_ack   <= 1'b0;
      savestate_load_busy  <= 1'b0;
      savestate_load_ok    <= 1'b0;
      ss_halt              <= 1'b0;
      ss_reset             <= 1'b0;
      load_take            <= 1'b0;
      save_put             <= 1'b0;
      bus_addr             <= '0;
      bus_wren             <= 1'b0;
      // Restores the bank defaults
      bus_reset            <= 1'b1;
    end else begin
      load_take <= 1'b0;
      save_put  <= 1'b0;
      bus_wren  <= 1'b0;
      bus_reset <= 1'b0;
      if (apf_delay != '0) begin
        apf_delay <= apf_delay - 1'b1;
      end

      case (state)
        idle: begin
          ss_halt  <= 1'b0;
          bus_addr <= '0;
          if (savestate_start) begin
            state                <= save_ack;
            apf_delay            <= phase_len;
            savestate_start_ack  <= 1'b1;
            savestate_start_ok   <= 1'b0;
            savestate_load_ok    <= 1'b0;
          end else if (load_full) begin
            // First word wraps the address to 0
            state    <= load_data;
            bus_addr <= '1;
            ss_halt  <= 1'b1;
          end
        end

        save_ack: begin
          if (apf_delay == '0) begin
            state                <= save_wait_ready;
            apf_delay            <= phase_len;
            savestate_start_ack  <= 1'b0;
            savestate_start_busy <= 1'b1;
          end
        end
        save_wait_ready: begin
          if (ss_ready && apf_delay == '0) begin
            state                <= save_read;
            savestate_start_busy <= 1'b0;
            savestate_start_ok   <= 1'b1;
            ss_halt              <= 1'b1;
            wait_cnt             <= wait_w'(1);
          end
        end
        save_read: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == wait_w'(`SS_READ_WAIT - 1)) begin
            save_put <= 1'b1;
          end
          // save_full is visible one cycle after the put
          if (wait_cnt == wait_w'(`SS_READ_WAIT)) begin
            state <= save_wait_host;
          end
        end
        save_wait_host: begin
          if (!save_full) begin
            if (bus_addr == last_addr) begin
              state   <= idle;
              ss_halt <= 1'b0;
            end else begin
              state    <= save_read;
              bus_addr <= bus_addr + 1'b1;
              wait_cnt <= wait_w'(1);
            end
          end
        end

        load_data: begin
          if (bus_addr == last_addr) begin
            state <= load_wait_req;
          end else if (load_full) begin
            state     <= load_write;
            load_take <= 1'b1;
            bus_wdata <= load_word;
          end
        end
        load_write: begin
          state    <= load_data;
          bus_addr <= bus_addr + 1'b1;
          bus_wren <= 1'b1;
        end
        load_wait_req: begin
          if (savestate_load) begin
            state               <= load_ack;
            apf_delay           <= phase_len;
            savestate_load_ack  <= 1'b1;
            savestate_load_ok   <= 1'b0;
            savestate_start_ok  <= 1'b0;
            ss_reset            <= 1'b1;
          end
        end
        load_ack: begin
          if (apf_delay == '0) begin
            state               <= load_busy;
            apf_delay           <= phase_len;
            savestate_load_ack  <= 1'b0;
            savestate_load_busy <= 1'b1;
          end
        end
        load_busy: begin
          if (apf_delay == '0) begin
            state               <= idle;
            savestate_load_busy <= 1'b0;
            savestate_load_ok   <= 1'b1;
            ss_reset            <= 1'b0;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/ss_bridge_port.sv
`timescale 1ns/10ps
`default_nettype none

module ss_bridge_port (
  input  wire              clk_sys,
  input  wire              reset,
  input  wire              bridge_wr,
  input  wire              bridge_rd,
  input  wire [31:0]       bridge_addr,
  input  wire ss_pkg::ss_word_t bridge_wr_data,
  output ss_pkg::ss_word_t bridge_rd_data,
  input  wire              load_take,
  output logic             load_full,
  output ss_pkg::ss_word_t load_word,
  input  wire              save_put,
  input  wire ss_pkg::ss_word_t bus_rdata,
  output logic             save_full
);
  import ss_pkg::*;
  `include "ss_defines.svh"

  // Byte size of the load window
  localparam logic [27:0] window_bytes = 28'(`SS_STATE_WORDS * 4);

  logic     in_region;
  logic     wr_hit;
  logic     rd_hit;
  ss_word_t save_word;

  // Host words are big-endian by nibble
  function automatic ss_word_t nibble_swap(input ss_word_t w);
    ss_word_t r;
    for (int n = 0; n < 8; n++) begin
      r[4*n +: 4] = w[28 - 4*n +: 4];
    end
    return r;
  endfunction

  assign in_region = bridge_addr[31:28] == 4'(`SS_BRIDGE_REGION);
  assign wr_hit = bridge_wr && in_region && (bridge_addr[27:0] < window_bytes);
  assign rd_hit = bridge_rd && in_region;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      load_full <= 1'b0;
      save_full <= 1'b0;
    end else begin
      if (wr_hit) begin
        load_full <= 1'b1;
      end else if (load_take) begin
        load_full <= 1'b0;
      end
      // A host read frees the save buffer
      if (save_put) begin
        save_full <= 1'b1;
      end else if (rd_hit) begin
        save_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (wr_hit) begin
      load_word <= nibble_swap(bridge_wr_data);
    end
    if (save_put) begin
      save_word <= bus_rdata;
    end
    if (rd_hit) begin
      bridge_rd_data <= nibble_swap(save_word);
    end
  end

endmodule

`default_nettype wire

//--- rtl/ss_pkg.sv
`default_nettype none

package ss_pkg;

  // One save-state word as seen on the bus
  typedef logic [31:0] ss_word_t;

  // Bus address, upper bits pick the bank, low nibble the word
  typedef logic [7:0] ss_addr_t;

  typedef enum logic [3:0] {
    idle,
    save_ack,
    save_wait_ready,
    save_read,
    save_wait_host,
    load_data,
    load_write,
    load_wait_req,
    load_ack,
    load_busy
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- include/ss_defines.svh
`ifndef SS_DEFINES_SVH
`define SS_DEFINES_SVH

// Register banks on the save-state bus, one per emulated block
`define SS_NUM_BANKS 4

// Words held by one bank
`define SS_BANK_WORDS 16

// Words in a complete save state
`define SS_STATE_WORDS 64

// Top address nibble of the host bridge window
`define SS_BRIDGE_REGION 4

// Cycles each ack or busy phase is held
`define SS_APF_DELAY 3

// Cycles from bus address to read word capture
// Decoder, bank and mux add one register each, plus one for capture
`define SS_READ_WAIT 4

`endif
